// File: design/soc_pkg.sv
`default_nettype none

package soc_pkg;

   // Bus fields
   typedef logic [31:0] wb_adr_t;
   typedef logic [31:0] wb_dat_t;
   typedef logic [3:0]  wb_sel_t;

   // Slave select from address bits 31:28
   typedef logic [3:0] region_t;

   localparam region_t REGION_RAM   = 4'h0;
   localparam region_t REGION_IO    = 4'h4;
   localparam region_t REGION_TIMER = 4'h8;

   localparam int RAM_WORDS = 256;

   typedef logic [$clog2(RAM_WORDS)-1:0] ram_idx_t; // Word index from adr[9:2]

   // I/O block word offsets in adr[3:2]
   localparam logic [1:0] IO_GPIO  = 2'd0;
   localparam logic [1:0] IO_PRINT = 2'd1;
   localparam logic [1:0] IO_HALT  = 2'd2;

   // Timer word offsets in adr[2]
   localparam logic TMR_MTIME    = 1'b0;
   localparam logic TMR_MTIMECMP = 1'b1;

   typedef enum logic [1:0] {
      ARB_IDLE,
      ARB_FETCH,
      ARB_DATA
   } arb_state_t;

endpackage

`default_nettype wire

// File: design/wb_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wb_bus_if import soc_pkg::*; ();

   wb_adr_t adr;
   wb_dat_t dat;
   wb_sel_t sel;
   logic    we;
   logic    cyc;
   logic    stb;
   wb_dat_t rdt;
   logic    ack;

   modport master (output adr, dat, sel, we, cyc, stb,
                   input  rdt, ack);

   modport slave  (input  adr, dat, sel, we, cyc, stb,
                   output rdt, ack);

   // Read-only instruction side
   modport fetch  (input  adr, cyc, stb,
                   output rdt, ack);

endinterface

`default_nettype wire

// File: design/wb_intercon.sv
`timescale 1ns/1ps
`default_nettype none

module wb_intercon import soc_pkg::*; (
   input  logic      wb_clk,
   input  logic      i_rst_n,
   wb_bus_if.fetch   ibus,
   wb_bus_if.slave   dbus,
   wb_bus_if.master  ram_bus,
   wb_bus_if.master  tmr_bus,
   wb_bus_if.master  io_bus
);

   arb_state_t grant;

   // Request of the granted master
   wb_adr_t m_adr;
   wb_dat_t m_dat;
   wb_sel_t m_sel;
   logic    m_we;
   logic    m_cyc;
   logic    m_stb;

   region_t region;
   logic    hit_ram;
   logic    hit_io;
   logic    hit_tmr;
   logic    unmapped;

   wb_dat_t s_rdt;
   logic    s_ack;
   logic    unm_ack;

   always_comb begin
      m_adr = dbus.adr;
      m_dat = dbus.dat;
      m_sel = dbus.sel;
      m_we  = 1'b0;
      m_cyc = 1'b0;
      m_stb = 1'b0;
      case (grant)
         ARB_DATA: begin
            m_we  = dbus.we;
            m_cyc = dbus.cyc;
            m_stb = dbus.stb;
         end
         ARB_FETCH: begin
            m_adr = ibus.adr;
            m_dat = '0;
            m_sel = '1;         // Instruction fetch reads whole words
            m_cyc = ibus.cyc;
            m_stb = ibus.stb;
         end
         default: ;
      endcase
   end

   assign region   = m_adr[31:28];
   assign hit_ram  = (region == REGION_RAM);
   assign hit_io   = (region == REGION_IO);
   assign hit_tmr  = (region == REGION_TIMER);
   assign unmapped = !(hit_ram || hit_io || hit_tmr);

   // Request fields fan out and strobes go to one slave only
   assign ram_bus.adr = m_adr;
   assign ram_bus.dat = m_dat;
   assign ram_bus.sel = m_sel;
   assign ram_bus.we  = m_we;
   assign ram_bus.cyc = m_cyc && hit_ram;
   assign ram_bus.stb = m_stb && hit_ram;

   assign tmr_bus.adr = m_adr;
   assign tmr_bus.dat = m_dat;
   assign tmr_bus.sel = m_sel;
   assign tmr_bus.we  = m_we;
   assign tmr_bus.cyc = m_cyc && hit_tmr;
   assign tmr_bus.stb = m_stb && hit_tmr;

   assign io_bus.adr = m_adr;
   assign io_bus.dat = m_dat;
   assign io_bus.sel = m_sel;
   assign io_bus.we  = m_we;
   assign io_bus.cyc = m_cyc && hit_io;
   assign io_bus.stb = m_stb && hit_io;

   // Answer unmapped accesses one cycle later
   always_ff @(posedge wb_clk) begin
      if (!i_rst_n)
         unm_ack <= 1'b0;
      else
         unm_ack <= m_cyc && m_stb && unmapped && !unm_ack;
   end

   always_comb begin
      s_rdt = '0;
      s_ack = unm_ack;
      if (hit_ram) begin
         s_rdt = ram_bus.rdt;
         s_ack = ram_bus.ack;
      end else if (hit_io) begin
         s_rdt = io_bus.rdt;
         s_ack = io_bus.ack;
      end else if (hit_tmr) begin
         s_rdt = tmr_bus.rdt;
         s_ack = tmr_bus.ack;
      end
   end

   always_ff @(posedge wb_clk) begin
      if (!i_rst_n) begin
         grant <= ARB_IDLE;
      end else begin
         case (grant)
            ARB_IDLE: begin
               if (dbus.cyc && dbus.stb)      // Data bus has priority
                  grant <= ARB_DATA;
               else if (ibus.cyc && ibus.stb)
                  grant <= ARB_FETCH;
            end
            default: begin
               if (s_ack || !m_cyc)           // Done or master gave up
                  grant <= ARB_IDLE;
            end
         endcase
      end
   end

   assign dbus.rdt = (grant == ARB_DATA)  ? s_rdt : '0;
   assign dbus.ack = (grant == ARB_DATA)  && s_ack;
   assign ibus.rdt = (grant == ARB_FETCH) ? s_rdt : '0;
   assign ibus.ack = (grant == ARB_FETCH) && s_ack;

endmodule

`default_nettype wire

// File: design/wb_ram.sv
`timescale 1ns/1ps
`default_nettype none

module wb_ram import soc_pkg::*; (
   input  logic     wb_clk,
   input  logic     i_rst_n,
   wb_bus_if.slave  bus
);

   wb_dat_t  mem [RAM_WORDS];
   ram_idx_t idx;
   wb_dat_t  rdt;
   logic     ack;
   logic     req;

   assign idx = bus.adr[$bits(ram_idx_t)+1:2];
   assign req = bus.cyc && bus.stb && !ack;  // Once per access

   // Byte lane writes
   always_ff @(posedge wb_clk) begin
      if (req && bus.we) begin
         for (int b = 0; b < 4; b++) begin
            if (bus.sel[b])
               mem[idx][b*8 +: 8] <= bus.dat[b*8 +: 8];
         end
      end
   end

   always_ff @(posedge wb_clk) begin
      rdt <= mem[idx];  // Valid alongside ack
   end

   always_ff @(posedge wb_clk) begin
      if (!i_rst_n)
         ack <= 1'b0;
      else
         ack <= req;
   end

   assign bus.rdt = rdt;
   assign bus.ack = ack;

endmodule

`default_nettype wire

// File: design/riscv_timer.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_timer import soc_pkg::*; (
   input  logic     wb_clk,
   input  logic     i_rst_n,
   wb_bus_if.slave  bus,
   output logic     o_irq
);

   wb_dat_t mtime;
   wb_dat_t mtimecmp;
   wb_dat_t rdt;
   logic    ack;
   logic    req;
   logic    wr;

   assign req = bus.cyc && bus.stb && !ack;
   assign wr  = req && bus.we;

   always_ff @(posedge wb_clk) begin
      if (!i_rst_n) begin
         mtime    <= '0;
         mtimecmp <= '1;   // No interrupt until software sets a compare value
      end else begin
         if (wr && bus.adr[2] == TMR_MTIME)
            mtime <= bus.dat;
         else
            mtime <= mtime + 1'b1;

         if (wr && bus.adr[2] == TMR_MTIMECMP) begin
            for (int b = 0; b < 4; b++) begin
               if (bus.sel[b])
                  mtimecmp[b*8 +: 8] <= bus.dat[b*8 +: 8];
            end
         end
      end
   end

   always_ff @(posedge wb_clk) begin
      if (!i_rst_n)
         o_irq <= 1'b0;
      else
         o_irq <= (mtime >= mtimecmp);  // Unsigned compare
   end

   always_ff @(posedge wb_clk) begin
      rdt <= (bus.adr[2] == TMR_MTIMECMP) ? mtimecmp : mtime;
   end

   always_ff @(posedge wb_clk) begin
      if (!i_rst_n)
         ack <= 1'b0;
      else
         ack <= req;
   end

   assign bus.rdt = rdt;
   assign bus.ack = ack;

endmodule

`default_nettype wire

// File: design/wb_sys_io.sv
`timescale 1ns/1ps
`default_nettype none

module wb_sys_io import soc_pkg::*; (
   input  logic       wb_clk,
   input  logic       i_rst_n,
   wb_bus_if.slave    bus,
   output logic       o_gpio,
   output logic [7:0] o_print_char,
   output logic       o_print_valid,
   output logic       o_halt
);

   logic [1:0] offs;
   wb_dat_t    rdt;
   logic       ack;
   logic       req;
   logic       wr;

   assign offs = bus.adr[3:2];
   assign req  = bus.cyc && bus.stb && !ack;
   assign wr   = req && bus.we;

   always_ff @(posedge wb_clk) begin
      if (!i_rst_n) begin
         o_gpio        <= 1'b0;
         o_print_valid <= 1'b0;
         o_halt        <= 1'b0;
      end else begin
         if (wr && offs == IO_GPIO)
            o_gpio <= bus.dat[0];
         o_print_valid <= wr && (offs == IO_PRINT);  // Lines up with ack
         if (wr && offs == IO_HALT)
            o_halt <= 1'b1;                           // Sticky
      end
   end

   always_ff @(posedge wb_clk) begin
      if (wr && offs == IO_PRINT)
         o_print_char <= bus.dat[7:0];
   end

   // Only the GPIO bit reads back
   always_ff @(posedge wb_clk) begin
      rdt <= (offs == IO_GPIO) ? {31'd0, o_gpio} : '0;
   end

   always_ff @(posedge wb_clk) begin
      if (!i_rst_n)
         ack <= 1'b0;
      else
         ack <= req;
   end

   assign bus.rdt = rdt;
   assign bus.ack = ack;

endmodule

`default_nettype wire

// File: design/serv_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module serv_wrapper import soc_pkg::*; (
   input  logic       wb_clk,
   input  logic       i_rst_n,
   // Instruction fetch bus
   input  wb_adr_t    i_ibus_adr,
   input  logic       i_ibus_cyc,
   input  logic       i_ibus_stb,
   output wb_dat_t    o_ibus_rdt,
   output logic       o_ibus_ack,
   // Data bus
   input  wb_adr_t    i_dbus_adr,
   input  wb_dat_t    i_dbus_dat,
   input  wb_sel_t    i_dbus_sel,
   input  logic       i_dbus_we,
   input  logic       i_dbus_cyc,
   input  logic       i_dbus_stb,
   output wb_dat_t    o_dbus_rdt,
   output logic       o_dbus_ack,
   // Peripherals
   output logic       o_gpio,
   output logic       o_timer_irq,
   output logic [7:0] o_print_char,
   output logic       o_print_valid,
   output logic       o_halt
);

   wb_bus_if ibus ();
   wb_bus_if dbus ();
   wb_bus_if ram_bus ();
   wb_bus_if tmr_bus ();
   wb_bus_if io_bus ();

   assign ibus.adr = i_ibus_adr;
   assign ibus.cyc = i_ibus_cyc;
   assign ibus.stb = i_ibus_stb;
   assign o_ibus_rdt = ibus.rdt;
   assign o_ibus_ack = ibus.ack;

   assign dbus.adr = i_dbus_adr;
   assign dbus.dat = i_dbus_dat;
   assign dbus.sel = i_dbus_sel;
   assign dbus.we  = i_dbus_we;
   assign dbus.cyc = i_dbus_cyc;
   assign dbus.stb = i_dbus_stb;
   assign o_dbus_rdt = dbus.rdt;
   assign o_dbus_ack = dbus.ack;

   wb_intercon intercon (
      .wb_clk  (wb_clk),
      .i_rst_n (i_rst_n),
      .ibus    (ibus.fetch),
      .dbus    (dbus.slave),
      .ram_bus (ram_bus.master),
      .tmr_bus (tmr_bus.master),
      .io_bus  (io_bus.master)
   );

   wb_ram ram (
      .wb_clk  (wb_clk),
      .i_rst_n (i_rst_n),
      .bus     (ram_bus.slave)
   );

   riscv_timer timer (
      .wb_clk  (wb_clk),
      .i_rst_n (i_rst_n),
      .bus     (tmr_bus.slave),
      .o_irq   (o_timer_irq)
   );

   wb_sys_io sys_io (
      .wb_clk        (wb_clk),
      .i_rst_n       (i_rst_n),
      .bus           (io_bus.slave),
      .o_gpio        (o_gpio),
      .o_print_char  (o_print_char),
      .o_print_valid (o_print_valid),
      .o_halt        (o_halt)
   );

endmodule

`default_nettype wire

// File: dv/serv_wrapper_chk.sv
`timescale 1ns/1ps
`default_nettype none

module serv_wrapper_chk import soc_pkg::*; (
   input wire        wb_clk,
   input wire        i_rst_n,
   input wire        i_ibus_cyc,
   input wire        i_ibus_stb,
   input wire        o_ibus_ack,
   input wire        i_dbus_cyc,
   input wire        i_dbus_stb,
   input wire        o_dbus_ack,
   input wire        o_gpio,
   input wire        o_timer_irq,
   input wire        o_print_valid,
   input wire        o_halt,
   input arb_state_t i_grant
);

   wire dreq = i_dbus_cyc && i_dbus_stb;
   wire ireq = i_ibus_cyc && i_ibus_stb;

   a_dack_pulse: assert property (@(posedge wb_clk) disable iff (!i_rst_n)
      o_dbus_ack |=> !o_dbus_ack) else $error("dbus ack longer than one cycle");
   a_iack_pulse: assert property (@(posedge wb_clk) disable iff (!i_rst_n)
      o_ibus_ack |=> !o_ibus_ack) else $error("ibus ack longer than one cycle");

   a_dack_req: assert property (@(posedge wb_clk) disable iff (!i_rst_n)
      o_dbus_ack |-> dreq) else $error("dbus ack without cyc and stb");
   a_iack_req: assert property (@(posedge wb_clk) disable iff (!i_rst_n)
      o_ibus_ack |-> ireq) else $error("ibus ack without cyc and stb");

   // Uncontested requests at an idle fabric
   a_dbus_latency: assert property (@(posedge wb_clk) disable iff (!i_rst_n)
      $rose(dreq) && i_grant == ARB_IDLE |-> ##2 o_dbus_ack)
      else $error("dbus ack not two edges after request");
   a_ibus_latency: assert property (@(posedge wb_clk) disable iff (!i_rst_n)
      $rose(ireq) && !dreq && i_grant == ARB_IDLE |-> ##2 o_ibus_ack)
      else $error("ibus ack not two edges after request");

   a_print_pulse: assert property (@(posedge wb_clk) disable iff (!i_rst_n)
      o_print_valid |=> !o_print_valid) else $error("print valid longer than one cycle");

   a_halt_sticky: assert property (@(posedge wb_clk) disable iff (!i_rst_n)
      !$fell(o_halt)) else $error("halt flag cleared without reset");

   a_reset_state: assert property (@(posedge wb_clk)
      $rose(i_rst_n) |-> !o_dbus_ack && !o_ibus_ack && !o_gpio && !o_print_valid
                         && !o_halt && !o_timer_irq)
      else $error("control outputs not low after reset");

endmodule

bind serv_wrapper serv_wrapper_chk chk (
   .wb_clk        (wb_clk),
   .i_rst_n       (i_rst_n),
   .i_ibus_cyc    (i_ibus_cyc),
   .i_ibus_stb    (i_ibus_stb),
   .o_ibus_ack    (o_ibus_ack),
   .i_dbus_cyc    (i_dbus_cyc),
   .i_dbus_stb    (i_dbus_stb),
   .o_dbus_ack    (o_dbus_ack),
   .o_gpio        (o_gpio),
   .o_timer_irq   (o_timer_irq),
   .o_print_valid (o_print_valid),
   .o_halt        (o_halt),
   .i_grant       (intercon.grant)
);

`default_nettype wire

// File: dv/tb_serv_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module tb_serv_wrapper import soc_pkg::*; ();

   localparam int MAX_CYCLES = 3000;
   localparam int N_WORDS    = 20;

   logic wb_clk, i_rst_n;
   wb_adr_t i_ibus_adr, i_dbus_adr;
   wb_dat_t i_dbus_dat, o_ibus_rdt, o_dbus_rdt;
   wb_sel_t i_dbus_sel;
   logic i_ibus_cyc, i_ibus_stb, o_ibus_ack;
   logic i_dbus_we, i_dbus_cyc, i_dbus_stb, o_dbus_ack;
   logic o_gpio, o_timer_irq, o_print_valid, o_halt;
   logic [7:0] o_print_char;

   int errors = 0;
   int cycles = 0;
   int dack_cnt = 0;
   int iack_cnt = 0;
   int print_cnt = 0;
   logic [7:0] print_seen;
   time dack_t, iack_t;
   logic [31:0] rng = 32'd33210;
   wb_dat_t shadow [RAM_WORDS];
   ram_idx_t used [N_WORDS];

   serv_wrapper i_dut (.*);

   initial begin
      wb_clk = 1'b0;
      forever #2 wb_clk = ~wb_clk;
   end

   // Watchdog
   always @(posedge wb_clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Test failures found");
         $finish;
      end
   end

   always @(negedge wb_clk) begin
      if (o_dbus_ack) dack_cnt++;
      if (o_ibus_ack) iack_cnt++;
      if (o_print_valid) begin
         print_cnt++;
         print_seen = o_print_char;
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         errors++;
         $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel);
      @(negedge wb_clk);
      i_dbus_adr = adr;
      i_dbus_dat = dat;
      i_dbus_sel = sel;
      i_dbus_we  = 1'b1;
      i_dbus_cyc = 1'b1;
      i_dbus_stb = 1'b1;
      do @(negedge wb_clk); while (!o_dbus_ack);
      dack_t = $time;
      @(negedge wb_clk);
      i_dbus_cyc = 1'b0;
      i_dbus_stb = 1'b0;
      i_dbus_we  = 1'b0;
   endtask

   task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat);
      @(negedge wb_clk);
      i_dbus_adr = adr;
      i_dbus_we  = 1'b0;
      i_dbus_cyc = 1'b1;
      i_dbus_stb = 1'b1;
      do @(negedge wb_clk); while (!o_dbus_ack);
      dat = o_dbus_rdt;
      dack_t = $time;
      @(negedge wb_clk);
      i_dbus_cyc = 1'b0;
      i_dbus_stb = 1'b0;
   endtask

   task automatic wb_fetch(input wb_adr_t adr, output wb_dat_t dat);
      @(negedge wb_clk);
      i_ibus_adr = adr;
      i_ibus_cyc = 1'b1;
      i_ibus_stb = 1'b1;
      do @(negedge wb_clk); while (!o_ibus_ack);
      dat = o_ibus_rdt;
      iack_t = $time;
      @(negedge wb_clk);
      i_ibus_cyc = 1'b0;
      i_ibus_stb = 1'b0;
   endtask

   function automatic wb_adr_t ram_adr(input ram_idx_t idx);
      return {REGION_RAM, 18'd0, idx, 2'b00};
   endfunction

   initial begin
      wb_dat_t d, d2, t0, t1;
      wb_sel_t sel;
      int n, dc, ic;
      logic [7:0] ch;
      i_rst_n = 1'b0;
      i_ibus_adr = '0;
      i_ibus_cyc = 1'b0;
      i_ibus_stb = 1'b0;
      i_dbus_adr = '0;
      i_dbus_dat = '0;
      i_dbus_sel = '0;
      i_dbus_we  = 1'b0;
      i_dbus_cyc = 1'b0;
      i_dbus_stb = 1'b0;
      repeat (10) @(negedge wb_clk);
      i_rst_n = 1'b1;
      @(negedge wb_clk);
      check_val("o_gpio", 0, o_gpio);
      check_val("o_halt", 0, o_halt);
      check_val("o_print_valid", 0, o_print_valid);
      check_val("o_timer_irq", 0, o_timer_irq);

      // RAM full words then partial merges
      for (int i = 0; i < N_WORDS; i++) begin
         rng = xorshift(rng);
         used[i] = rng[7:0];
         rng = xorshift(rng);
         shadow[used[i]] = rng;
         wb_write(ram_adr(used[i]), rng, 4'hf);
         rng = xorshift(rng);
         d = rng;
         rng = xorshift(rng);
         sel = rng[3:0];
         for (int b = 0; b < 4; b++)
            if (sel[b]) shadow[used[i]][b*8 +: 8] = d[b*8 +: 8];
         wb_write(ram_adr(used[i]), d, sel);
      end
      for (int i = 0; i < N_WORDS; i++) begin
         wb_read(ram_adr(used[i]), d);
         check_val("o_dbus_rdt", shadow[used[i]], d);
         wb_fetch(ram_adr(used[i]), d);
         check_val("o_ibus_rdt", shadow[used[i]], d);
      end

      // Data bus wins a contested access
      dc = dack_cnt;
      ic = iack_cnt;
      fork
         wb_read(ram_adr(used[0]), d);
         wb_fetch(ram_adr(used[1]), d2);
      join
      check_val("o_dbus_rdt", shadow[used[0]], d);
      check_val("o_ibus_rdt", shadow[used[1]], d2);
      check_val("dbus ack count", 1, dack_cnt - dc);
      check_val("ibus ack count", 1, iack_cnt - ic);
      assert (dack_t < iack_t) else begin
         errors++;
         $display("Fetch bus was acknowledged before the data bus in a contested access");
      end

      // Timer
      wb_read({REGION_TIMER, 28'h0}, t0);
      wb_read({REGION_TIMER, 28'h0}, t1);
      check_val("mtime increasing", 1, t1 > t0);
      wb_write({REGION_TIMER, 28'h4}, t1 + 40, 4'hf);
      for (int i = 0; i < 20; i++) begin
         @(negedge wb_clk);
         check_val("o_timer_irq", 0, o_timer_irq);
      end
      n = 0;
      while (!o_timer_irq && n < 40) begin
         @(negedge wb_clk);
         n++;
      end
      check_val("o_timer_irq", 1, o_timer_irq);
      wb_write({REGION_TIMER, 28'h4}, 32'hffff_ffff, 4'hf);
      repeat (2) @(negedge wb_clk);
      check_val("o_timer_irq", 0, o_timer_irq);

      // GPIO, print and halt
      wb_write({REGION_IO, 28'h0}, 32'd1, 4'hf);
      check_val("o_gpio", 1, o_gpio);
      wb_read({REGION_IO, 28'h0}, d);
      check_val("o_dbus_rdt", 1, d);
      wb_write({REGION_IO, 28'h0}, 32'd0, 4'hf);
      check_val("o_gpio", 0, o_gpio);
      wb_read({REGION_IO, 28'h0}, d);
      check_val("o_dbus_rdt", 0, d);
      rng = xorshift(rng);
      ch = rng[7:0];
      n = print_cnt;
      wb_write({REGION_IO, 28'h4}, {24'd0, ch}, 4'hf);
      repeat (2) @(negedge wb_clk);
      check_val("o_print_valid pulses", 1, print_cnt - n);
      check_val("o_print_char", ch, print_seen);
      wb_write({REGION_IO, 28'h8}, 32'd1, 4'hf);
      check_val("o_halt", 1, o_halt);
      wb_read(ram_adr(used[2]), d);
      wb_fetch(ram_adr(used[3]), d);
      check_val("o_halt", 1, o_halt);

      // Unmapped region aliasing the RAM index of used[4]
      wb_read(32'h2000_0000, d);
      check_val("o_dbus_rdt", 0, d);
      wb_write({4'h2, 18'd0, used[4], 2'b00}, ~shadow[used[4]], 4'hf);
      wb_read(ram_adr(used[4]), d);
      check_val("o_dbus_rdt", shadow[used[4]], d);

      repeat (4) @(negedge wb_clk);
      $display("Checks failed: %0d", errors);
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
design/soc_pkg.sv
design/wb_bus_if.sv
design/wb_intercon.sv
design/wb_ram.sv
design/riscv_timer.sv
design/wb_sys_io.sv
design/serv_wrapper.sv
dv/serv_wrapper_chk.sv
dv/tb_serv_wrapper.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_serv_wrapper
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
